// ==== axi_remap.f ====
+incdir+rtl
rtl/axi_remap_pkg.sv
rtl/axi_addr_remap.sv
rtl/axi_modify_address.sv
rtl/axi_sram_slave.sv
rtl/axi_remap_top.sv
verif/axi_remap_sva.sv
verif/axi_remap_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the axi_remap simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/axi_remap_sim

# Compile RTL, assertions and testbench into one binary
verilator --binary --timing --assert -Wno-fatal \
  -f axi_remap.f --top-module axi_remap_tb -o axi_remap_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

# Run from the project root so the cases file path resolves
"$SIM_BIN" > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $SIM_LOG"
  exit 1
fi

# Result comes from the log
if grep -q "Verification failed" "$SIM_LOG"; then
  echo "Test failed, see $SIM_LOG"
  exit 1
fi
if ! grep -q "Verification passed" "$SIM_LOG"; then
  echo "No result found in $SIM_LOG"
  exit 1
fi
echo "Test passed"
exit 0

// ==== verif/axi_remap_cases.txt ====
# Columns, all values hex:
#   cfg idx en base size_log2 target | wr id addr len data strb | rd id addr len
# No rule enabled after reset, addresses pass through as their low 12 bits
wr 1 80000300 0 deadbeef f
rd 1 80000300 0
rd 2 00000300 0
# Rule 0, 256-byte window at 0x80000000 onto 0x400
cfg 0 1 80000000 08 400
wr 3 80000010 0 cafef00d f
rd 3 80000010 0
rd 4 00000410 0
wr 5 12345100 0 01020304 f
rd 5 00000100 0
# Rule 1, 4 KiB window over the same base onto 0x800, rule 0 keeps priority
cfg 1 1 80000000 0c 800
wr 6 80000020 0 11112222 f
rd 6 00000420 0
# Rule 0 off, later accesses land in rule 1
cfg 0 0 80000000 08 400
wr 7 80000020 0 33334444 f
rd 7 80000020 0
rd 8 00000820 0
rd 9 00000420 0
# Target plus offset truncated to 12 bits, 0x800 + 0x900 lands on 0x100
wr 4 80000900 0 feedface f
rd 5 00000100 0
# INCR bursts with partial strobes
wr a 80000100 7 a0000000 f
wr b 80000104 2 55aa0000 5
rd c 80000100 7
wr d 80000040 0 12345678 f
wr e 80000040 0 9abcdef0 c
rd f 80000040 0
wr 1 80000200 3 00c0ffee f
wr 2 80000204 1 77665544 2
rd 3 80000200 3

// ==== verif/axi_remap_tb.sv ====
// Testbench for axi_remap_top that runs table, write and read cases from a file and checks data
`timescale 1ns/100ps
`include "axi_remap_defines.svh"

module axi_remap_tb;

  localparam int IDX_W = $clog2(`AXI_REMAP_NUM_RULES);

  // DUT ports
  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic                       cfg_we_i;
  logic [IDX_W-1:0]           cfg_idx_i;
  axi_remap_pkg::remap_rule_t cfg_rule_i;
  axi_remap_pkg::slv_req_t    slv_req;
  axi_remap_pkg::axi_rsp_t    slv_rsp;

  // Reference rule table and SRAM-side byte memory
  axi_remap_pkg::remap_rule_t rule_model [`AXI_REMAP_NUM_RULES];
  logic [7:0]                 mem_model [4*`AXI_REMAP_MEM_WORDS];

  int    error_cnt = 0;
  int    check_cnt = 0;
  int    cycle_cnt = 0;
  int    limit_cycles = 0;
  string lines [$];

  axi_remap_top UUT (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .slv_req_i  ( slv_req    ),
    .slv_rsp_o  ( slv_rsp    ),
    .cfg_we_i   ( cfg_we_i   ),
    .cfg_idx_i  ( cfg_idx_i  ),
    .cfg_rule_i ( cfg_rule_i )
  );

  // 10 ns clock
  always #5 clk_i = ~clk_i;

  // Closing count line and the verdict
  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // Run limit takes effect once the cases file is read
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_cycles > 0 && cycle_cnt >= limit_cycles) begin
      error_cnt++;
      $display("Timeout: run did not finish within %0d cycles", limit_cycles);
      finish_run();
    end
  end

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // First enabled window that holds the address or the low 12 bits as passthrough
  function automatic logic [11:0] expect_addr(input logic [31:0] addr);
    logic [31:0] span;
    logic [31:0] sum;
    logic [11:0] res;
    logic        hit;
    res = addr[11:0];
    hit = 1'b0;
    for (int i = 0; i < `AXI_REMAP_NUM_RULES; i++) begin
      if (!hit && rule_model[i].en &&
          (addr >> rule_model[i].size_log2) == (rule_model[i].base >> rule_model[i].size_log2)) begin
        span = 32'd1 << rule_model[i].size_log2;
        sum  = {20'd0, rule_model[i].target} + (addr % span);
        res  = sum[11:0];
        hit  = 1'b1;
      end
    end
    return res;
  endfunction

  // Word of a burst beat with wrap inside the SRAM
  function automatic logic [31:0] model_word(input logic [11:0] sub, input int beat);
    int base;
    base = 4 * ((sub / 4 + beat) % `AXI_REMAP_MEM_WORDS);
    return {mem_model[base+3], mem_model[base+2], mem_model[base+1], mem_model[base]};
  endfunction

  task automatic store_beat(input logic [11:0] sub, input int beat, input logic [31:0] data,
                            input logic [3:0] strb);
    int base;
    base = 4 * ((sub / 4 + beat) % `AXI_REMAP_MEM_WORDS);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) mem_model[base+b] = data[b*8 +: 8];
    end
  endtask

  // One-cycle table write that is visible from the next cycle
  task automatic write_rule(input logic [IDX_W-1:0] idx, input axi_remap_pkg::remap_rule_t rule);
    cfg_we_i   = 1'b1;
    cfg_idx_i  = idx;
    cfg_rule_i = rule;
    step();
    cfg_we_i = 1'b0;
    rule_model[idx] = rule;
  endtask

  task automatic do_write(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                          input logic [31:0] data0, input logic [3:0] strb);
    logic [11:0] sub;
    logic        accepted;
    sub = expect_addr(addr);
    slv_req.aw       = '0;
    slv_req.aw.id    = id;
    slv_req.aw.addr  = addr;
    slv_req.aw.len   = len;
    slv_req.aw.size  = 3'd2;
    slv_req.aw.burst = 2'b01;
    slv_req.aw_valid = 1'b1;
    // Burst goes out twice so the repeat AW stalls behind the first one
    for (int rep = 0; rep < 2; rep++) begin
      do begin
        @(negedge clk_i);
        accepted = slv_rsp.aw_ready;
        if (accepted) check_val("mst_req.aw.addr", UUT.mst_req.aw.addr, sub);
        check_val("b_valid", slv_rsp.b_valid, 1'b0);
        step();
      end while (!accepted);
      // Repeat AW stays pending through the first burst
      slv_req.aw_valid = (rep == 0);
      // Data beats count up from the start word
      for (int beat = 0; beat <= len; beat++) begin
        slv_req.w.data  = data0 + beat;
        slv_req.w.strb  = strb;
        slv_req.w.last  = (beat == len);
        slv_req.w_valid = 1'b1;
        do begin
          @(negedge clk_i);
          accepted = slv_rsp.w_ready;
          step();
        end while (!accepted);
        store_beat(sub, beat, data0 + beat, strb);
      end
      slv_req.w_valid = 1'b0;
      // Response under random back-pressure
      accepted = 1'b0;
      while (!accepted) begin
        slv_req.b_ready = ($urandom % 4) != 0;
        @(negedge clk_i);
        if (slv_rsp.b_valid && slv_req.b_ready) begin
          check_val("b.id", slv_rsp.b.id, id);
          check_val("b.resp", slv_rsp.b.resp, 2'b00);
          accepted = 1'b1;
        end
        step();
      end
      slv_req.b_ready = 1'b0;
    end
    // Exactly one response per burst
    @(negedge clk_i);
    check_val("b_valid", slv_rsp.b_valid, 1'b0);
    step();
  endtask

  task automatic do_read(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len);
    logic [11:0] sub;
    logic        accepted;
    int          beat;
    sub = expect_addr(addr);
    slv_req.ar       = '0;
    slv_req.ar.id    = id;
    slv_req.ar.addr  = addr;
    slv_req.ar.len   = len;
    slv_req.ar.size  = 3'd2;
    slv_req.ar.burst = 2'b01;
    slv_req.ar_valid = 1'b1;
    // Burst is read twice so the repeat AR stalls behind the first one
    for (int rep = 0; rep < 2; rep++) begin
      do begin
        @(negedge clk_i);
        accepted = slv_rsp.ar_ready;
        if (accepted) check_val("mst_req.ar.addr", UUT.mst_req.ar.addr, sub);
        check_val("r_valid", slv_rsp.r_valid, 1'b0);
        step();
      end while (!accepted);
      // Repeat AR stays pending through the first burst
      slv_req.ar_valid = (rep == 0);
      beat = 0;
      while (beat <= len) begin
        slv_req.r_ready = ($urandom % 4) != 0;
        @(negedge clk_i);
        if (slv_rsp.r_valid && slv_req.r_ready) begin
          check_val("r.data", slv_rsp.r.data, model_word(sub, beat));
          check_val("r.id", slv_rsp.r.id, id);
          check_val("r.resp", slv_rsp.r.resp, 2'b00);
          check_val("r.last", slv_rsp.r.last, beat == len);
          beat++;
        end
        step();
      end
      slv_req.r_ready = 1'b0;
    end
    // No extra beat after r_last
    @(negedge clk_i);
    check_val("r_valid", slv_rsp.r_valid, 1'b0);
    step();
  endtask

  // Parse one line of the cases file and run it
  task automatic run_line(input string line);
    string                      kind;
    int                         n;
    logic [31:0]                f1;
    logic [31:0]                f2;
    logic [31:0]                f3;
    logic [31:0]                f4;
    logic [31:0]                f5;
    axi_remap_pkg::remap_rule_t rule;
    kind = "";
    n = $sscanf(line, "%s %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
    // Blank and comment lines
    if (n < 1 || kind.len() == 0 || kind.getc(0) == "#") return;
    if (kind == "cfg" && n == 6) begin
      rule.en        = f2[0];
      rule.base      = f3;
      rule.size_log2 = f4[4:0];
      rule.target    = f5[11:0];
      write_rule(f1[IDX_W-1:0], rule);
    end else if (kind == "wr" && n == 6) begin
      do_write(f1[3:0], f2, f3[7:0], f4, f5[3:0]);
    end else if (kind == "rd" && n == 4) begin
      do_read(f1[3:0], f2, f3[7:0]);
    end else begin
      error_cnt++;
      $display("Error: malformed line in cases file: %s", line);
    end
  endtask

  initial begin
    int    fd;
    string line;
    rst_n_i    = 1'b0;
    cfg_we_i   = 1'b0;
    cfg_idx_i  = '0;
    cfg_rule_i = '0;
    slv_req    = '0;
    void'($urandom(32'h7830));
    foreach (rule_model[i]) rule_model[i] = '0;
    foreach (mem_model[i]) mem_model[i] = 8'hxx;
    fd = $fopen("verif/axi_remap_cases.txt", "r");
    if (fd == 0) begin
      error_cnt++;
      $display("Error: could not open the cases file verif/axi_remap_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) lines.push_back(line);
      end
      $fclose(fd);
    end
    limit_cycles = 40 * lines.size() + 100;
    // Reset for 3 cycles
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Idle state right after reset
    @(negedge clk_i);
    check_val("aw_ready", slv_rsp.aw_ready, 1'b1);
    check_val("ar_ready", slv_rsp.ar_ready, 1'b1);
    check_val("w_ready", slv_rsp.w_ready, 1'b0);
    check_val("b_valid", slv_rsp.b_valid, 1'b0);
    check_val("r_valid", slv_rsp.r_valid, 1'b0);
    step();
    foreach (lines[i]) run_line(lines[i]);
    finish_run();
  end

endmodule

// ==== verif/axi_remap_sva.sv ====
// axi_remap_sva: handshake stability checks on the SRAM-side AXI channels
`timescale 1ns/100ps

module axi_remap_sva (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input axi_remap_pkg::mst_req_t req_i,
  input axi_remap_pkg::axi_rsp_t rsp_i
);

  // AW valid and the whole AW payload, address included, hold until aw_ready
  property aw_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (req_i.aw_valid && !rsp_i.aw_ready) |=> (req_i.aw_valid && $stable(req_i.aw));
  endproperty
  aw_hold_a: assert property (aw_hold_p)
    else $error("AW valid or payload changed before aw_ready");

  // Same on the read address channel
  property ar_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (req_i.ar_valid && !rsp_i.ar_ready) |=> (req_i.ar_valid && $stable(req_i.ar));
  endproperty
  ar_hold_a: assert property (ar_hold_p)
    else $error("AR valid or payload changed before ar_ready");

  // Write response stays up until b_ready
  property b_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (rsp_i.b_valid && !req_i.b_ready) |=> (rsp_i.b_valid && $stable(rsp_i.b));
  endproperty
  b_hold_a: assert property (b_hold_p)
    else $error("B valid dropped or payload changed while stalled");

  // Read beat frozen under r_ready low
  property r_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (rsp_i.r_valid && !req_i.r_ready) |=> (rsp_i.r_valid && $stable(rsp_i.r));
  endproperty
  r_hold_a: assert property (r_hold_p)
    else $error("R valid dropped or payload changed while stalled");

endmodule

// Checker attached to the SRAM subordinate
bind axi_sram_slave axi_remap_sva i_axi_remap_sva (
  .clk_i   ( clk_i   ),
  .rst_n_i ( rst_n_i ),
  .req_i   ( req_i   ),
  .rsp_i   ( rsp_o   )
);

// ==== rtl/axi_remap_top.sv ====
// axi_remap_top: address remap table and modifier in front of an AXI4 SRAM
`timescale 1ns/100ps
`include "axi_remap_defines.svh"

module axi_remap_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Manager-side AXI4 port
  input  axi_remap_pkg::slv_req_t                 slv_req_i,
  output axi_remap_pkg::axi_rsp_t                 slv_rsp_o,
  // Rule table write port
  input  logic                                    cfg_we_i,
  input  logic [$clog2(`AXI_REMAP_NUM_RULES)-1:0] cfg_idx_i,
  input  axi_remap_pkg::remap_rule_t              cfg_rule_i
);

  // Translated addresses
  logic [`AXI_REMAP_MST_ADDR_W-1:0] mst_aw_addr;
  logic [`AXI_REMAP_MST_ADDR_W-1:0] mst_ar_addr;
  // SRAM-side bus
  axi_remap_pkg::mst_req_t          mst_req;
  axi_remap_pkg::axi_rsp_t          mst_rsp;

  // Window table lookup
  axi_addr_remap i_axi_addr_remap (
    .clk_i         ( clk_i              ),
    .rst_n_i       ( rst_n_i            ),
    .cfg_we_i      ( cfg_we_i           ),
    .cfg_idx_i     ( cfg_idx_i          ),
    .cfg_rule_i    ( cfg_rule_i         ),
    .slv_aw_addr_i ( slv_req_i.aw.addr  ),
    .slv_ar_addr_i ( slv_req_i.ar.addr  ),
    .mst_aw_addr_o ( mst_aw_addr        ),
    .mst_ar_addr_o ( mst_ar_addr        )
  );

  // Address swap into the request
  axi_modify_address i_axi_modify_address (
    .slv_req_i     ( slv_req_i   ),
    .slv_rsp_o     ( slv_rsp_o   ),
    .mst_aw_addr_i ( mst_aw_addr ),
    .mst_ar_addr_i ( mst_ar_addr ),
    .mst_req_o     ( mst_req     ),
    .mst_rsp_i     ( mst_rsp     )
  );

  // Target memory
  axi_sram_slave i_axi_sram_slave (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( mst_req ),
    .rsp_o   ( mst_rsp )
  );

endmodule

// ==== rtl/axi_sram_slave.sv ====
// axi_sram_slave: AXI4 subordinate on a word SRAM, one INCR burst at a time per direction
`timescale 1ns/100ps
`include "axi_remap_defines.svh"

module axi_sram_slave (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axi_remap_pkg::mst_req_t req_i,
  output axi_remap_pkg::axi_rsp_t rsp_o
);

  // Word index width, byte lanes per word
  localparam int unsigned WORD_W = $clog2(`AXI_REMAP_MEM_WORDS);
  localparam int unsigned NUM_BYTES = `AXI_REMAP_DATA_W / 8;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  typedef enum logic {
    R_IDLE,
    R_DATA
  } rd_state_e;

  // Backing store, no reset
  logic [`AXI_REMAP_DATA_W-1:0] mem_q [`AXI_REMAP_MEM_WORDS];

  // Write path state
  wr_state_e                   wr_state_q;
  logic [7:0]                  wr_cnt_q;
  logic [7:0]                  wr_len_q;
  logic [WORD_W-1:0]           wr_word_q;
  logic [`AXI_REMAP_ID_W-1:0]  wr_id_q;

  // Read path state
  rd_state_e                    rd_state_q;
  logic [7:0]                   rd_cnt_q;
  logic [7:0]                   rd_len_q;
  logic [WORD_W-1:0]            rd_word_q;
  logic [`AXI_REMAP_ID_W-1:0]   rd_id_q;
  logic [`AXI_REMAP_DATA_W-1:0] rd_data_q;

  // Handshake events
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic r_last;
  // Word address of the first beat, taken from the byte address
  logic [WORD_W-1:0] aw_word;
  logic [WORD_W-1:0] ar_word;

  assign aw_word = req_i.aw.addr[WORD_W+1:2];
  assign ar_word = req_i.ar.addr[WORD_W+1:2];

  assign aw_hs  = req_i.aw_valid && (wr_state_q == W_IDLE);
  assign w_hs   = req_i.w_valid && (wr_state_q == W_DATA);
  assign b_hs   = req_i.b_ready && (wr_state_q == W_RESP);
  assign ar_hs  = req_i.ar_valid && (rd_state_q == R_IDLE);
  assign r_last = (rd_cnt_q == rd_len_q);
  assign r_hs   = req_i.r_ready && (rd_state_q == R_DATA);

  // Write FSM, control only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= W_IDLE;
      wr_cnt_q   <= '0;
    end else begin
      case (wr_state_q)
        W_IDLE: if (aw_hs) begin
          wr_state_q <= W_DATA;
          wr_cnt_q   <= '0;
        end
        W_DATA: if (w_hs) begin
          // Beat count decides the end of the burst
          wr_cnt_q <= wr_cnt_q + 8'd1;
          if (wr_cnt_q == wr_len_q) wr_state_q <= W_RESP;
        end
        W_RESP: if (b_hs) wr_state_q <= W_IDLE;
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  // Write burst payload and byte-masked memory update
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_id_q   <= req_i.aw.id;
      wr_len_q  <= req_i.aw.len;
      wr_word_q <= aw_word;
    end
    if (w_hs) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (req_i.w.strb[b]) mem_q[wr_word_q][b*8 +: 8] <= req_i.w.data[b*8 +: 8];
      end
      // Next word, wraps within the array
      wr_word_q <= wr_word_q + 1'b1;
    end
  end

  // Read FSM, control only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_state_q <= R_IDLE;
      rd_cnt_q   <= '0;
    end else begin
      case (rd_state_q)
        R_IDLE: if (ar_hs) begin
          rd_state_q <= R_DATA;
          rd_cnt_q   <= '0;
        end
        R_DATA: if (r_hs) begin
          rd_cnt_q <= rd_cnt_q + 8'd1;
          if (r_last) rd_state_q <= R_IDLE;
        end
        default: rd_state_q <= R_IDLE;
      endcase
    end
  end

  // Read data registered, so R payload holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rd_id_q   <= req_i.ar.id;
      rd_len_q  <= req_i.ar.len;
      rd_word_q <= ar_word + 1'b1;
      rd_data_q <= mem_q[ar_word];
    end else if (r_hs && !r_last) begin
      // Prefetch the following beat
      rd_word_q <= rd_word_q + 1'b1;
      rd_data_q <= mem_q[rd_word_q];
    end
  end

  // Response bundle, always OKAY with the ID echoed
  always_comb begin
    rsp_o.aw_ready = (wr_state_q == W_IDLE);
    rsp_o.w_ready  = (wr_state_q == W_DATA);
    rsp_o.b_valid  = (wr_state_q == W_RESP);
    rsp_o.b.id     = wr_id_q;
    rsp_o.b.resp   = 2'b00;
    rsp_o.b.user   = '0;
    rsp_o.ar_ready = (rd_state_q == R_IDLE);
    rsp_o.r_valid  = (rd_state_q == R_DATA);
    rsp_o.r.id     = rd_id_q;
    rsp_o.r.data   = rd_data_q;
    rsp_o.r.resp   = 2'b00;
    rsp_o.r.last   = r_last;
    rsp_o.r.user   = '0;
  end

endmodule

// ==== rtl/axi_modify_address.sv ====
// axi_modify_address: swaps remapped AW and AR addresses into an AXI4 request, rest passes through
`timescale 1ns/100ps
`include "axi_remap_defines.svh"

module axi_modify_address (
  // Manager-side request and its response
  input  axi_remap_pkg::slv_req_t                 slv_req_i,
  output axi_remap_pkg::axi_rsp_t                 slv_rsp_o,
  // Replacement addresses, held stable while the handshake is pending
  input  logic [`AXI_REMAP_MST_ADDR_W-1:0]        mst_aw_addr_i,
  input  logic [`AXI_REMAP_MST_ADDR_W-1:0]        mst_ar_addr_i,
  // Subordinate-side request and its response
  output axi_remap_pkg::mst_req_t                 mst_req_o,
  input  axi_remap_pkg::axi_rsp_t                 mst_rsp_i
);

  // Request rebuilt field by field, only addr differs
  always_comb begin
    // AW channel
    mst_req_o.aw.id     = slv_req_i.aw.id;
    mst_req_o.aw.addr   = mst_aw_addr_i;
    mst_req_o.aw.len    = slv_req_i.aw.len;
    mst_req_o.aw.size   = slv_req_i.aw.size;
    mst_req_o.aw.burst  = slv_req_i.aw.burst;
    mst_req_o.aw.lock   = slv_req_i.aw.lock;
    mst_req_o.aw.cache  = slv_req_i.aw.cache;
    mst_req_o.aw.prot   = slv_req_i.aw.prot;
    mst_req_o.aw.qos    = slv_req_i.aw.qos;
    mst_req_o.aw.region = slv_req_i.aw.region;
    // Atomic op carried along untouched
    mst_req_o.aw.atop   = slv_req_i.aw.atop;
    mst_req_o.aw.user   = slv_req_i.aw.user;
    mst_req_o.aw_valid  = slv_req_i.aw_valid;
    // W and B handshake, no change
    mst_req_o.w         = slv_req_i.w;
    mst_req_o.w_valid   = slv_req_i.w_valid;
    mst_req_o.b_ready   = slv_req_i.b_ready;
    // AR channel
    mst_req_o.ar.id     = slv_req_i.ar.id;
    mst_req_o.ar.addr   = mst_ar_addr_i;
    mst_req_o.ar.len    = slv_req_i.ar.len;
    mst_req_o.ar.size   = slv_req_i.ar.size;
    mst_req_o.ar.burst  = slv_req_i.ar.burst;
    mst_req_o.ar.lock   = slv_req_i.ar.lock;
    mst_req_o.ar.cache  = slv_req_i.ar.cache;
    mst_req_o.ar.prot   = slv_req_i.ar.prot;
    mst_req_o.ar.qos    = slv_req_i.ar.qos;
    mst_req_o.ar.region = slv_req_i.ar.region;
    mst_req_o.ar.user   = slv_req_i.ar.user;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    // R handshake
    mst_req_o.r_ready   = slv_req_i.r_ready;
  end

  // Response goes back as is
  assign slv_rsp_o = mst_rsp_i;

endmodule

// ==== rtl/axi_addr_remap.sv ====
// axi_addr_remap: programmable window table translating AW and AR addresses to SRAM space
`timescale 1ns/100ps
`include "axi_remap_defines.svh"

module axi_addr_remap (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Table write port, plain strobe without acknowledge
  input  logic                                       cfg_we_i,
  input  logic [$clog2(`AXI_REMAP_NUM_RULES)-1:0]    cfg_idx_i,
  input  axi_remap_pkg::remap_rule_t                 cfg_rule_i,
  // Manager-side addresses taken straight off the request
  input  logic [`AXI_REMAP_SLV_ADDR_W-1:0]           slv_aw_addr_i,
  input  logic [`AXI_REMAP_SLV_ADDR_W-1:0]           slv_ar_addr_i,
  // Translated addresses, combinational
  output logic [`AXI_REMAP_MST_ADDR_W-1:0]           mst_aw_addr_o,
  output logic [`AXI_REMAP_MST_ADDR_W-1:0]           mst_ar_addr_o
);

  // Rule table, all windows disabled after reset
  axi_remap_pkg::remap_rule_t [`AXI_REMAP_NUM_RULES-1:0] rule_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rule_q <= '0;
    end else if (cfg_we_i) begin
      // New rule visible from the next cycle on
      rule_q[cfg_idx_i] <= cfg_rule_i;
    end
  end

  // Priority window match on one address
  function automatic logic [`AXI_REMAP_MST_ADDR_W-1:0] remap_addr(
    input logic [`AXI_REMAP_SLV_ADDR_W-1:0]                addr,
    input axi_remap_pkg::remap_rule_t [`AXI_REMAP_NUM_RULES-1:0] rules
  );
    logic [`AXI_REMAP_SLV_ADDR_W-1:0] mask;
    logic [`AXI_REMAP_SLV_ADDR_W-1:0] sum;
    logic [`AXI_REMAP_MST_ADDR_W-1:0] res;
    // Passthrough of the low bits when no window hits
    res = addr[`AXI_REMAP_MST_ADDR_W-1:0];
    // Walk downwards so the lowest matching index is the last one applied
    for (int i = `AXI_REMAP_NUM_RULES - 1; i >= 0; i--) begin
      // Offset mask of the window
      mask = (`AXI_REMAP_SLV_ADDR_W'(1) << rules[i].size_log2) - 1'b1;
      if (rules[i].en &&
          ((addr >> rules[i].size_log2) == (rules[i].base >> rules[i].size_log2))) begin
        // Target plus offset, truncated to the subordinate width
        sum = `AXI_REMAP_SLV_ADDR_W'(rules[i].target) + (addr & mask);
        res = sum[`AXI_REMAP_MST_ADDR_W-1:0];
      end
    end
    return res;
  endfunction

  // Same lookup on both address channels
  always_comb begin
    mst_aw_addr_o = remap_addr(slv_aw_addr_i, rule_q);
    mst_ar_addr_o = remap_addr(slv_ar_addr_i, rule_q);
  end

endmodule

// ==== rtl/axi_remap_pkg.sv ====
// axi_remap types: AXI4 channel, request and response structs plus the remap rule
`include "axi_remap_defines.svh"

package axi_remap_pkg;

  // Basic field types
  typedef logic [`AXI_REMAP_ID_W-1:0]       id_t;
  typedef logic [`AXI_REMAP_SLV_ADDR_W-1:0] slv_addr_t;
  typedef logic [`AXI_REMAP_MST_ADDR_W-1:0] mst_addr_t;
  typedef logic [`AXI_REMAP_DATA_W-1:0]     data_t;
  typedef logic [`AXI_REMAP_DATA_W/8-1:0]   strb_t;
  typedef logic [`AXI_REMAP_USER_W-1:0]     user_t;

  // AW channel, manager side with full address
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } slv_aw_chan_t;

  // AW channel, subordinate side with SRAM address
  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } mst_aw_chan_t;

  // AR channel, manager side
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } slv_ar_chan_t;

  // AR channel, subordinate side
  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } mst_ar_chan_t;

  // W, B and R channels are shared by both sides
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
    user_t      user;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
    user_t      user;
  } r_chan_t;

  // Request bundles, one per side
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  // Response bundle, identical on both sides
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_rsp_t;

  // One remap window: base aligned to 2**size_log2, mapped onto target
  typedef struct packed {
    logic       en;
    slv_addr_t  base;
    logic [4:0] size_log2;
    mst_addr_t  target;
  } remap_rule_t;

endpackage

// ==== rtl/axi_remap_defines.svh ====
// axi_remap defines: bus widths, window count and SRAM depth of the remap subsystem
`ifndef AXI_REMAP_DEFINES_SVH
`define AXI_REMAP_DEFINES_SVH

// Manager-side address width
`define AXI_REMAP_SLV_ADDR_W 32
// Subordinate-side address width, covers the SRAM byte space
`define AXI_REMAP_MST_ADDR_W 12
// Data width, strobe is one bit per byte
`define AXI_REMAP_DATA_W 32
// Transaction ID width
`define AXI_REMAP_ID_W 4
// User signal width on all channels
`define AXI_REMAP_USER_W 1
// Number of remap windows in the rule table
`define AXI_REMAP_NUM_RULES 4
// SRAM depth in data words
`define AXI_REMAP_MEM_WORDS 1024

`endif
